// File: Makefile
SIM  := obj_dir/Veeprom_tb
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module eeprom_tb

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: bus_sync.sv
`default_nettype none

module bus_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic dat,
    output logic scl_s,
    output logic dat_s,
    output logic start_det,
    output logic stop_det,
    output logic scl_rise,
    output logic scl_fall
);

    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic                   scl_d;
    logic                   dat_d;

    assign scl_s = scl_sync[SYNC_STAGES-1];
    assign dat_s = dat_sync[SYNC_STAGES-1];

    // Both lines idle high, so reset loads ones to avoid false edges.
    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            scl_sync  <= '1;
            dat_sync  <= '1;
            scl_d     <= 1'b1;
            dat_d     <= 1'b1;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
        end
        else
        begin
            scl_sync  <= {scl_sync[SYNC_STAGES-2:0], scl};
            dat_sync  <= {dat_sync[SYNC_STAGES-2:0], dat};
            scl_d     <= scl_s;
            dat_d     <= dat_s;
            scl_rise  <= scl_s & ~scl_d;
            scl_fall  <= ~scl_s & scl_d;
            // A data edge counts only with scl steady high on both samples.
            start_det <= scl_s & scl_d & dat_d & ~dat_s;
            stop_det  <= scl_s & scl_d & ~dat_d & dat_s;
        end
    end

    // The master holds each scl level for at least SYNC_STAGES + 3 cycles.
    assert property (@(posedge sda) disable iff (rst)
        scl_fall |-> $past(scl_s, SYNC_STAGES + 4))
        else $error("scl high phase shorter than the synchronizer allows");

    assert property (@(posedge sda) disable iff (rst)
        scl_rise |-> !$past(scl_s, SYNC_STAGES + 4))
        else $error("scl low phase shorter than the synchronizer allows");

endmodule

`default_nettype wire

// File: byte_shifter.sv
`default_nettype none

module byte_shifter (
    input  logic                          sda,
    input  logic                          rst,
    input  logic                          scl_rise,
    input  logic                          scl_fall,
    input  logic                          start_det,
    input  logic                          dat_s,
    input  logic                          do_ack,
    input  logic                          load_tx,
    input  logic                          tx_mode,
    input  logic [eeprom_pkg::data_w-1:0] tx_byte,
    output logic [eeprom_pkg::data_w-1:0] rx_byte,
    output logic                          byte_done,
    output logic                          ack_slot,
    output logic                          master_ack,
    output logic                          dat_oe
);

    import eeprom_pkg::*;

    // Number of scl rises seen in the current byte, 8 means the ninth slot is open.
    logic [3:0]        bit_cnt;
    logic [data_w-1:0] tx_sr;
    logic              ack_phase;

    assign ack_phase = (bit_cnt == 4'd8);

    // The fall that ends the eighth bit opens the acknowledge slot.
    assign ack_slot = scl_fall && ack_phase;

    // Only a low line that this device does not pull counts as the master's ack.
    assign master_ack = scl_rise && ack_phase && !dat_s && !dat_oe;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            bit_cnt   <= 4'd0;
            byte_done <= 1'b0;
            dat_oe    <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (start_det)
            begin
                bit_cnt <= 4'd0;
                dat_oe  <= 1'b0;
            end
            else
            begin
                if (scl_rise)
                begin
                    if (ack_phase)
                    begin
                        bit_cnt <= 4'd0;
                    end
                    else
                    begin
                        bit_cnt   <= bit_cnt + 4'd1;
                        byte_done <= (bit_cnt == 4'd7);
                    end
                end
                // A pulled line is a zero bit, hence the inversion.
                if (scl_fall)
                begin
                    if (ack_phase)
                        dat_oe <= do_ack;
                    else
                        dat_oe <= tx_mode & ~tx_sr[data_w-1];
                end
            end
        end
    end

    // Data bits arrive MSB first.
    always_ff @(posedge sda)
    begin
        if (scl_rise && !ack_phase)
            rx_byte <= {rx_byte[data_w-2:0], dat_s};
    end

    always_ff @(posedge sda)
    begin
        if (load_tx)
            tx_sr <= tx_byte;
        else if (scl_fall && !ack_phase && tx_mode)
            tx_sr <= {tx_sr[data_w-2:0], 1'b0};
    end

endmodule

`default_nettype wire

// File: compile.f
eeprom_pkg.sv
bus_sync.sv
byte_shifter.sv
eeprom_ctrl.sv
eeprom_array.sv
eeprom_top.sv
tb_clock_gen.sv
eeprom_tb.sv

// File: eeprom_array.sv
`default_nettype none

module eeprom_array (
    input  logic                          sda,
    input  logic                          wr_en,
    input  logic [eeprom_pkg::addr_w-1:0] wr_addr,
    input  logic [eeprom_pkg::data_w-1:0] wr_data,
    input  logic                          rd_en,
    input  logic [eeprom_pkg::addr_w-1:0] rd_addr,
    output logic [eeprom_pkg::data_w-1:0] rd_data
);

    import eeprom_pkg::*;

    logic [data_w-1:0] mem [mem_depth];

    always_ff @(posedge sda)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered read, data is valid the cycle after rd_en.
    always_ff @(posedge sda)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: eeprom_ctrl.sv
`default_nettype none

module eeprom_ctrl (
    input  logic                          sda,
    input  logic                          rst,
    input  logic                          start_det,
    input  logic                          stop_det,
    input  logic                          byte_done,
    input  logic                          ack_slot,
    input  logic                          master_ack,
    input  logic [eeprom_pkg::data_w-1:0] rx_byte,
    input  logic [eeprom_pkg::data_w-1:0] rd_data,
    output logic                          do_ack,
    output logic                          load_tx,
    output logic [eeprom_pkg::data_w-1:0] tx_byte,
    output logic                          tx_mode,
    output logic                          wr_en,
    output logic [eeprom_pkg::addr_w-1:0] wr_addr,
    output logic [eeprom_pkg::data_w-1:0] wr_data,
    output logic                          rd_en,
    output logic [eeprom_pkg::addr_w-1:0] rd_addr
);

    import eeprom_pkg::*;

    ctrl_state_t       state;
    logic [addr_w-1:0] addr;
    logic              rd_req;
    logic              dev_match;

    assign dev_match = (rx_byte[data_w-1:data_w-4] == dev_code);

    // The address register always points at the next byte to send.
    assign rd_addr = addr;

    // The array's registered output is ready when load_tx fires.
    assign tx_byte = rd_data;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state   <= idle;
            addr    <= '0;
            rd_req  <= 1'b0;
            do_ack  <= 1'b0;
            tx_mode <= 1'b0;
            wr_en   <= 1'b0;
            rd_en   <= 1'b0;
            load_tx <= 1'b0;
        end
        else
        begin
            wr_en   <= 1'b0;
            rd_en   <= 1'b0;
            load_tx <= rd_en;
            if (start_det)
            begin
                state   <= get_ctrl;
                do_ack  <= 1'b0;
                tx_mode <= 1'b0;
            end
            else if (stop_det)
            begin
                state   <= idle;
                do_ack  <= 1'b0;
                tx_mode <= 1'b0;
            end
            else
            begin
                case (state)
                    idle:
                    begin
                        // Waits for a start.
                    end
                    get_ctrl:
                    begin
                        if (byte_done)
                        begin
                            if (dev_match)
                            begin
                                do_ack                 <= 1'b1;
                                addr[addr_w-1:data_w]  <= rx_byte[3:1];
                                rd_req                 <= rx_byte[0];
                            end
                            else
                            begin
                                state <= ignore;
                            end
                        end
                        else if (ack_slot && do_ack)
                        begin
                            if (rd_req)
                            begin
                                // The first byte is fetched while the ack is on the line.
                                state   <= send_data;
                                do_ack  <= 1'b0;
                                tx_mode <= 1'b1;
                                rd_en   <= 1'b1;
                            end
                            else
                            begin
                                state <= get_addr;
                            end
                        end
                    end
                    get_addr:
                    begin
                        if (byte_done)
                        begin
                            addr[data_w-1:0] <= rx_byte;
                            state            <= get_data;
                        end
                    end
                    get_data:
                    begin
                        if (byte_done)
                        begin
                            wr_en <= 1'b1;
                            addr  <= addr + 1'b1;
                        end
                    end
                    send_data:
                    begin
                        // Line is released for the master's ack, which refills the shifter.
                        if (ack_slot)
                        begin
                            addr    <= addr + 1'b1;
                            tx_mode <= 1'b0;
                        end
                        else if (master_ack)
                        begin
                            rd_en   <= 1'b1;
                            tx_mode <= 1'b1;
                        end
                    end
                    ignore:
                    begin
                        // Foreign device code, stays silent until start or stop.
                    end
                    default:
                    begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (byte_done && state == get_data)
        begin
            wr_addr <= addr;
            wr_data <= rx_byte;
        end
    end

    // A byte and its acknowledge slot on the same cycle would lose the ack decision.
    assert property (@(posedge sda) disable iff (rst) !(byte_done && ack_slot))
        else $error("byte_done and ack_slot arrived in the same cycle");

endmodule

`default_nettype wire

// File: eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // Memory geometry of a 16 Kbit part.
    localparam int addr_w = 11;
    localparam int data_w = 8;
    localparam int mem_depth = 2048;

    // Device type code in the upper nibble of the control byte.
    localparam logic [3:0] dev_code = 4'b1010;

    // Protocol states of the slave.
    typedef enum logic [2:0] {
        idle,
        get_ctrl,
        get_addr,
        get_data,
        send_data,
        ignore
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: eeprom_tb.sv
`default_nettype none

module eeprom_tb;

    import eeprom_pkg::*;

    typedef enum int {
        op_write,
        op_rand_read,
        op_cur_read,
        op_bad_write,
        op_abort_read
    } op_kind_t;

    typedef struct packed {
        op_kind_t   kind;
        logic [2:0] block;
        logic [7:0] word;
        int         count;
        logic [7:0] seed;
    } op_t;

    localparam int n_ops = 15;
    localparam int sync_stages = 2;
    // The device moves the line sync_stages + 2 cycles after scl falls.
    localparam int half_cycles = sync_stages + 4;
    localparam logic [3:0] foreign_code = 4'b0110;

    logic              sda;
    logic              rst;
    logic              scl;
    logic              dat_drv;
    logic              dat_line;
    logic              dat_oe;
    logic              bus_idle;
    logic              timed_out;
    int                errors;
    int                checks;
    logic [data_w-1:0] model [mem_depth];
    logic [addr_w-1:0] cur_addr;
    op_t               ops [n_ops];

    tb_clock_gen clk0 (
        .sda (sda),
        .rst (rst)
    );

    // Open-drain data line with an implicit pull-up.
    assign dat_line = dat_drv & ~dat_oe;

    eeprom_top #(
        .SYNC_STAGES (sync_stages)
    ) dut0 (
        .sda    (sda),
        .rst    (rst),
        .scl    (scl),
        .dat    (dat_line),
        .dat_oe (dat_oe)
    );

    task automatic load_table();
        ops[0]  = '{op_write,      3'd1, 8'h20, 1, 8'h00};
        ops[1]  = '{op_write,      3'd4, 8'h9c, 1, 8'h5a};
        ops[2]  = '{op_write,      3'd6, 8'h03, 1, 8'h3c};
        ops[3]  = '{op_rand_read,  3'd1, 8'h20, 1, 8'h00};
        ops[4]  = '{op_rand_read,  3'd4, 8'h9c, 1, 8'h00};
        ops[5]  = '{op_rand_read,  3'd6, 8'h03, 1, 8'h00};
        ops[6]  = '{op_write,      3'd7, 8'hfe, 5, 8'ha5};
        ops[7]  = '{op_rand_read,  3'd7, 8'hfe, 5, 8'h00};
        ops[8]  = '{op_write,      3'd2, 8'h10, 3, 8'h0f};
        ops[9]  = '{op_rand_read,  3'd2, 8'h10, 2, 8'h00};
        ops[10] = '{op_cur_read,   3'd2, 8'h00, 1, 8'h00};
        ops[11] = '{op_bad_write,  3'd4, 8'h9c, 2, 8'hff};
        ops[12] = '{op_rand_read,  3'd4, 8'h9c, 1, 8'h00};
        ops[13] = '{op_abort_read, 3'd7, 8'hfe, 2, 8'h00};
        ops[14] = '{op_rand_read,  3'd0, 8'h00, 3, 8'h00};
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge sda);
        #10;
    endtask

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Error at %0t: %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    // One bit slot, the master drives mid-low and samples mid-high.
    task automatic clock_bit(input logic drv, output logic smp);
        scl = 1'b0;
        step(2);
        dat_drv = drv;
        step(half_cycles - 2);
        scl = 1'b1;
        step(half_cycles / 2);
        smp = dat_line;
        step(half_cycles - half_cycles / 2);
    endtask

    task automatic bus_start();
        if (!bus_idle)
        begin
            scl = 1'b0;
            step(2);
            dat_drv = 1'b1;
            step(half_cycles - 2);
            scl = 1'b1;
        end
        step(half_cycles / 2);
        dat_drv = 1'b0;
        step(half_cycles - half_cycles / 2);
        bus_idle = 1'b0;
    endtask

    task automatic bus_stop();
        scl = 1'b0;
        step(2);
        dat_drv = 1'b0;
        step(half_cycles - 2);
        scl = 1'b1;
        step(half_cycles / 2);
        dat_drv = 1'b1;
        step(half_cycles - half_cycles / 2);
        bus_idle = 1'b1;
    endtask

    task automatic send_byte(input logic [7:0] b, input logic ack_exp);
        logic smp;
        for (int i = 7; i >= 0; i--)
            clock_bit(b[i], smp);
        clock_bit(1'b1, smp);
        check_value("ack", {7'b0, ack_exp}, {7'b0, ~smp});
    endtask

    task automatic recv_byte(input logic give_ack, output logic [7:0] b);
        logic smp;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, smp);
            b[i] = smp;
        end
        clock_bit(~give_ack, smp);
    endtask

    task automatic address_phase(input logic [2:0] block, input logic [7:0] word);
        bus_start();
        send_byte({dev_code, block, 1'b0}, 1'b1);
        send_byte(word, 1'b1);
    endtask

    // The master acks every byte but the last, unless ack_last is set.
    task automatic read_bytes(input int count, input logic [addr_w-1:0] first,
                              input logic ack_last);
        logic [7:0]        got;
        logic [addr_w-1:0] a;
        a = first;
        for (int i = 0; i < count; i++)
        begin
            recv_byte(ack_last || i < count - 1, got);
            check_value($sformatf("rd_byte[%h]", a), model[a], got);
            a = a + 11'd1;
        end
        cur_addr = a;
    endtask

    task automatic write_bytes(input op_t op);
        logic [addr_w-1:0] a;
        logic [31:0]       rnd;
        logic [7:0]        b;
        a = {op.block, op.word};
        address_phase(op.block, op.word);
        for (int i = 0; i < op.count; i++)
        begin
            rnd = $urandom;
            b = rnd[7:0] ^ op.seed;
            send_byte(b, 1'b1);
            model[a] = b;
            a = a + 11'd1;
        end
        bus_stop();
        cur_addr = a;
    endtask

    task automatic random_read(input op_t op);
        address_phase(op.block, op.word);
        bus_start();
        send_byte({dev_code, op.block, 1'b1}, 1'b1);
        read_bytes(op.count, {op.block, op.word}, 1'b0);
        bus_stop();
    endtask

    task automatic current_read(input op_t op);
        bus_start();
        send_byte({dev_code, op.block, 1'b1}, 1'b1);
        // The control byte replaces the block bits of the current address.
        read_bytes(op.count, {op.block, cur_addr[7:0]}, 1'b0);
        bus_stop();
    endtask

    task automatic foreign_write(input op_t op);
        logic [31:0] rnd;
        bus_start();
        send_byte({foreign_code, op.block, 1'b0}, 1'b0);
        send_byte(op.word, 1'b0);
        for (int i = 0; i < op.count; i++)
        begin
            rnd = $urandom;
            send_byte(rnd[7:0] ^ op.seed, 1'b0);
        end
        bus_stop();
    endtask

    task automatic aborted_read(input op_t op);
        logic [addr_w-1:0] a;
        logic              smp;
        int                stop_bit;
        address_phase(op.block, op.word);
        bus_start();
        send_byte({dev_code, op.block, 1'b1}, 1'b1);
        read_bytes(op.count, {op.block, op.word}, 1'b1);
        a = cur_addr;
        stop_bit = -1;
        for (int i = 7; i >= 0; i--)
            if (model[a][i] && stop_bit < 0)
                stop_bit = i;
        // A stop can only be made while the device leaves the line high.
        for (int i = 7; i > stop_bit; i--)
            clock_bit(1'b1, smp);
        if (stop_bit < 0)
        begin
            clock_bit(1'b0, smp);
            cur_addr = a + 11'd1;
        end
        bus_stop();
        // Once stopped, the device leaves the line high for every later slot.
        for (int i = 0; i < 9; i++)
        begin
            clock_bit(1'b1, smp);
            check_value("dat_line", 8'h01, {7'b0, smp});
        end
    endtask

    task automatic apply_op(input op_t op);
        case (op.kind)
            op_write:      write_bytes(op);
            op_rand_read:  random_read(op);
            op_cur_read:   current_read(op);
            op_bad_write:  foreign_write(op);
            op_abort_read: aborted_read(op);
            default:       $display("Unknown operation kind in the table");
        endcase
    endtask

    initial
    begin
        int n;
        scl = 1'b1;
        dat_drv = 1'b1;
        bus_idle = 1'b1;
        timed_out = 1'b0;
        errors = 0;
        checks = 0;
        cur_addr = '0;
        void'($urandom(32'ha4ec));
        for (int i = 0; i < mem_depth; i++)
            model[i] = 8'h00;
        load_table();

        n = 0;
        do
        begin
            @(posedge sda);
            n++;
        end
        while (rst && n < 200);
        #10;
        if (rst)
        begin
            timed_out = 1'b1;
            $display("Reset was still asserted after 200 cycles");
        end
        else
        begin
            for (int i = 0; i < 20; i++)
            begin
                step(1);
                check_value("dat_oe", 8'h00, {7'b0, dat_oe});
            end
            for (int i = 0; i < n_ops && !timed_out; i++)
                apply_op(ops[i]);
            step(20);
        end

        $display("Checks: %0d, errors: %0d, timed out: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: eeprom_top.sv
`default_nettype none

module eeprom_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic dat,
    output logic dat_oe
);

    import eeprom_pkg::*;

    logic              scl_s;
    logic              dat_s;
    logic              start_det;
    logic              stop_det;
    logic              scl_rise;
    logic              scl_fall;
    logic [data_w-1:0] rx_byte;
    logic              byte_done;
    logic              ack_slot;
    logic              master_ack;
    logic              do_ack;
    logic              load_tx;
    logic [data_w-1:0] tx_byte;
    logic              tx_mode;
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;
    logic              rd_en;
    logic [addr_w-1:0] rd_addr;
    logic [data_w-1:0] rd_data;

    bus_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) sync0 (
        .sda       (sda),
        .rst       (rst),
        .scl       (scl),
        .dat       (dat),
        .scl_s     (scl_s),
        .dat_s     (dat_s),
        .start_det (start_det),
        .stop_det  (stop_det),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall)
    );

    byte_shifter shift0 (
        .sda        (sda),
        .rst        (rst),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_det  (start_det),
        .dat_s      (dat_s),
        .do_ack     (do_ack),
        .load_tx    (load_tx),
        .tx_mode    (tx_mode),
        .tx_byte    (tx_byte),
        .rx_byte    (rx_byte),
        .byte_done  (byte_done),
        .ack_slot   (ack_slot),
        .master_ack (master_ack),
        .dat_oe     (dat_oe)
    );

    eeprom_ctrl ctrl0 (
        .sda        (sda),
        .rst        (rst),
        .start_det  (start_det),
        .stop_det   (stop_det),
        .byte_done  (byte_done),
        .ack_slot   (ack_slot),
        .master_ack (master_ack),
        .rx_byte    (rx_byte),
        .rd_data    (rd_data),
        .do_ack     (do_ack),
        .load_tx    (load_tx),
        .tx_byte    (tx_byte),
        .tx_mode    (tx_mode),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr)
    );

    eeprom_array array0 (
        .sda     (sda),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // The data line may only move while scl is low, apart from the release after a start.
    assert property (@(posedge sda) disable iff (rst)
        scl_s && !$past(start_det) && !$past(stop_det) |-> $stable(dat_oe))
        else $error("dat_oe changed while scl was high");

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic sda,
    output logic rst
);

    initial
    begin
        sda = 1'b0;
        forever
            #50 sda = ~sda;
    end

    // Reset spans ten rising edges and drops shortly after the last one.
    initial
    begin
        rst = 1'b1;
        repeat (10) @(posedge sda);
        #10;
        rst = 1'b0;
    end

endmodule

`default_nettype wire
